// ==== design/ray_pkg.sv ====
package ray_pkg;

    ////////////////////
    // screen and projection constants

    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;

    // focal length is 2**FOCAL_SHIFT pixels
    localparam int FOCAL_SHIFT = 10;

    // cube extent in x and y
    localparam int BLOCK_SIZE = 64;

    // the saber is a thin bar at a fixed slot
    localparam int SABER_WIDTH = 16;
    localparam int SABER_INDEX = 12;

    // depth reported when nothing is hit
    localparam logic [13:0] NO_HIT_T = '1;

    ////////////////////
    // shared data types

    typedef struct packed {
        logic              visible;
        logic signed [11:0] bx;
        logic signed [11:0] by;
        logic [13:0]        bz;
        logic               spare;
    } block_entry_t;

    typedef struct packed {
        logic [10:0] x;
        logic [9:0]  y;
    } pix_t;

    typedef struct packed {
        pix_t         pix;
        logic [3:0]   index;
        block_entry_t entry;
        logic         last;
        logic         valid;
    } scan_item_t;

    typedef struct packed {
        scan_item_t         scan;
        logic signed [11:0] dir_x;
        logic signed [10:0] dir_y;
    } ray_item_t;

    typedef struct packed {
        pix_t        pix;
        logic [3:0]  index;
        logic        hit;
        logic [13:0] t;
        logic        last;
        logic        valid;
    } hit_item_t;

endpackage

// ==== design/block_scanner.sv ====
`timescale 1ns/1ps

module block_scanner import ray_pkg::*; #(
    parameter int NUM_BLOCKS = 16
) (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         wr_en,
    input  logic [3:0]   wr_index,
    input  block_entry_t wr_entry,
    input  logic         pixel_valid,
    input  pix_t         pixel,
    output logic         busy,
    output scan_item_t   item
);

    // block table with one entry per cube slot
    block_entry_t blocks_q [NUM_BLOCKS];

    logic       busy_q;
    logic [3:0] cnt_q;
    pix_t       pix_q;
    logic       accept;
    logic       at_last;

    // strobes during a scan are dropped
    assign accept  = pixel_valid && !busy_q;
    assign at_last = (cnt_q == 4'(NUM_BLOCKS - 1));
    assign busy    = busy_q;

    ////////////////////
    // table writes

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            // every slot starts invisible
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                blocks_q[i].visible <= 1'b0;
            end
        end else if (wr_en && (int'(wr_index) < NUM_BLOCKS)) begin
            blocks_q[wr_index] <= wr_entry;
        end
    end

    ////////////////////
    // scan sequencer

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy_q     <= 1'b0;
            cnt_q      <= 4'd0;
            item.valid <= 1'b0;
        end else begin
            item.valid <= busy_q;
            if (accept) begin
                // latch pixel and start at entry 0 next cycle
                busy_q <= 1'b1;
                cnt_q  <= 4'd0;
                pix_q  <= pixel;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 4'd1;
                if (at_last) begin
                    busy_q <= 1'b0;
                end
            end
            // one entry per cycle while scanning
            item.pix   <= pix_q;
            item.index <= cnt_q;
            item.entry <= blocks_q[cnt_q];
            item.last  <= at_last;
        end
    end

endmodule

// ==== design/pixel_to_ray.sv ====
`timescale 1ns/1ps

module pixel_to_ray import ray_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  scan_item_t item_in,
    output ray_item_t  item_out
);

    scan_item_t         s1_item;
    logic signed [11:0] s1_dx;
    logic signed [10:0] s1_dy;

    ////////////////////
    // stage 1: centre the pixel

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_item.valid <= 1'b0;
        end else begin
            s1_item <= item_in;
            // eye sits on the screen centre, z is the focal length
            s1_dx <= $signed({1'b0, item_in.pix.x}) - 12'(SCREEN_W / 2);
            s1_dy <= $signed({1'b0, item_in.pix.y}) - 11'(SCREEN_H / 2);
        end
    end

    ////////////////////
    // stage 2: output register

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            item_out.scan.valid <= 1'b0;
        end else begin
            item_out.scan  <= s1_item;
            item_out.dir_x <= s1_dx;
            item_out.dir_y <= s1_dy;
        end
    end

endmodule

// ==== design/ray_box_test.sv ====
`timescale 1ns/1ps

module ray_box_test import ray_pkg::*; (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic signed [11:0] dir_x,
    input  logic signed [10:0] dir_y,
    input  block_entry_t       entry,
    input  logic               is_saber,
    input  logic               valid_in,
    output logic               hit,
    output logic [13:0]        t,
    output logic               valid_out
);

    // stage 1 products, 12x15 and 11x15 signed
    logic signed [26:0] prod_x_s1;
    logic signed [25:0] prod_y_s1;
    block_entry_t       ent_s1;
    logic               saber_s1;
    logic               valid_s1;

    // stage 2 face-plane hit point
    logic signed [17:0] hx_s2;
    logic signed [17:0] hy_s2;
    block_entry_t       ent_s2;
    logic               saber_s2;
    logic               valid_s2;

    // stage 3 bounds
    logic signed [17:0] x_lo;
    logic signed [17:0] x_hi;
    logic signed [17:0] y_lo;
    logic signed [17:0] y_hi;
    logic               in_x;
    logic               in_y;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            // scale direction by the face depth
            prod_x_s1 <= dir_x * $signed({1'b0, entry.bz});
            prod_y_s1 <= dir_y * $signed({1'b0, entry.bz});
            ent_s1    <= entry;
            saber_s1  <= is_saber;
            valid_s1  <= valid_in;

            // divide by focal length, keeps sign
            hx_s2    <= 18'(prod_x_s1 >>> FOCAL_SHIFT);
            hy_s2    <= 18'(prod_y_s1 >>> FOCAL_SHIFT);
            ent_s2   <= ent_s1;
            saber_s2 <= saber_s1;
            valid_s2 <= valid_s1;

            // zero depth never counts as a hit
            hit       <= in_x && in_y && (ent_s2.bz != 14'd0);
            t         <= ent_s2.bz;
            valid_out <= valid_s2;
        end
    end

    ////////////////////
    // extent check

    always_comb begin
        x_lo = 18'($signed(ent_s2.bx));
        y_lo = 18'($signed(ent_s2.by));
        // saber is narrower in x only
        x_hi = x_lo + (saber_s2 ? 18'(SABER_WIDTH) : 18'(BLOCK_SIZE));
        y_hi = y_lo + 18'(BLOCK_SIZE);
        in_x = (hx_s2 >= x_lo) && (hx_s2 < x_hi);
        in_y = (hy_s2 >= y_lo) && (hy_s2 < y_hi);
    end

endmodule

// ==== design/get_intersecting_block.sv ====
`timescale 1ns/1ps

module get_intersecting_block import ray_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  ray_item_t item_in,
    output hit_item_t item_out
);

    // side data that rides along with the box test
    typedef struct packed {
        pix_t       pix;
        logic [3:0] index;
        logic       visible;
        logic       last;
    } tag_t;

    tag_t        tag_q [3];
    logic        is_saber;
    logic        box_hit;
    logic [13:0] box_t;
    logic        box_valid;

    // saber slot gets the narrow extent
    assign is_saber = (item_in.scan.index == 4'(SABER_INDEX));

    ray_box_test u_box (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .dir_x     (item_in.dir_x),
        .dir_y     (item_in.dir_y),
        .entry     (item_in.scan.entry),
        .is_saber  (is_saber),
        .valid_in  (item_in.scan.valid),
        .hit       (box_hit),
        .t         (box_t),
        .valid_out (box_valid)
    );

    ////////////////////
    // 3-deep delay, matches box test latency

    always_ff @(posedge clk_in) begin
        tag_q[0].pix     <= item_in.scan.pix;
        tag_q[0].index   <= item_in.scan.index;
        tag_q[0].visible <= item_in.scan.entry.visible;
        tag_q[0].last    <= item_in.scan.last;
        tag_q[1]         <= tag_q[0];
        tag_q[2]         <= tag_q[1];
    end

    ////////////////////
    // output register

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            item_out.valid <= 1'b0;
        end else begin
            item_out.valid <= box_valid;
            // hidden blocks never report
            item_out.hit   <= box_hit && tag_q[2].visible;
            item_out.t     <= box_t;
            item_out.pix   <= tag_q[2].pix;
            item_out.index <= tag_q[2].index;
            item_out.last  <= tag_q[2].last;
        end
    end

endmodule

// ==== design/nearest_hit_reduce.sv ====
`timescale 1ns/1ps

module nearest_hit_reduce import ray_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  hit_item_t   item_in,
    output logic        hit_valid,
    output pix_t        pixel_out,
    output logic        hit,
    output logic [3:0]  block_index,
    output logic [13:0] best_t
);

    // running best for the pixel being scanned
    logic        first_q;
    logic        run_hit_q;
    logic [3:0]  run_idx_q;
    logic [13:0] run_t_q;

    logic        cur_hit;
    logic [3:0]  cur_idx;
    logic [13:0] cur_t;
    logic        take;
    logic        nxt_hit;
    logic [3:0]  nxt_idx;
    logic [13:0] nxt_t;

    always_comb begin
        // restart after a last item
        cur_hit = first_q ? 1'b0 : run_hit_q;
        cur_idx = first_q ? 4'd0 : run_idx_q;
        cur_t   = first_q ? NO_HIT_T : run_t_q;
        // strictly nearer only, so ties keep the lower index
        take    = item_in.hit && (!cur_hit || (item_in.t < cur_t));
        nxt_hit = cur_hit || take;
        nxt_idx = take ? item_in.index : cur_idx;
        nxt_t   = take ? item_in.t : cur_t;
    end

    ////////////////////
    // accumulate and emit

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            first_q   <= 1'b1;
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= item_in.valid && item_in.last;
            if (item_in.valid) begin
                first_q   <= item_in.last;
                run_hit_q <= nxt_hit;
                run_idx_q <= nxt_idx;
                run_t_q   <= nxt_t;
            end
            // final result for this pixel
            if (item_in.valid && item_in.last) begin
                pixel_out   <= item_in.pix;
                hit         <= nxt_hit;
                block_index <= nxt_idx;
                best_t      <= nxt_t;
            end
        end
    end

endmodule

// ==== design/block_selector.sv ====
`timescale 1ns/1ps

module block_selector import ray_pkg::*; #(
    parameter int NUM_BLOCKS = 16
) (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         wr_en,
    input  logic [3:0]   wr_index,
    input  block_entry_t wr_entry,
    input  logic         pixel_valid,
    input  pix_t         pixel,
    output logic         busy,
    output logic         hit_valid,
    output pix_t         pixel_out,
    output logic         hit,
    output logic [3:0]   block_index,
    output logic [13:0]  best_t
);

    // linear pipeline, scanner to reducer
    scan_item_t scan_item;
    ray_item_t  ray_item;
    hit_item_t  hit_item;

    block_scanner #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) u_scanner (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .busy        (busy),
        .item        (scan_item)
    );

    // +2 cycles
    pixel_to_ray u_ray (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .item_in  (scan_item),
        .item_out (ray_item)
    );

    // +4 cycles
    get_intersecting_block u_isect (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .item_in  (ray_item),
        .item_out (hit_item)
    );

    nearest_hit_reduce u_reduce (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .item_in     (hit_item),
        .hit_valid   (hit_valid),
        .pixel_out   (pixel_out),
        .hit         (hit),
        .block_index (block_index),
        .best_t      (best_t)
    );

endmodule

// ==== verification/block_selector_tb.sv ====
`timescale 1ns/1ps

module block_selector_tb import ray_pkg::*; ();

    localparam int NUM_BLOCKS = 16;
    localparam int CLK_PERIOD = 10;
    localparam int LATENCY    = NUM_BLOCKS + 7;
    localparam int NUM_RANDOM = 8;

    // one golden line where W uses a..e as index, visible, bx, by, bz
    // P uses a..e as x, y, hit, index, t
    typedef struct packed {
        logic is_write;
        int   a;
        int   b;
        int   c;
        int   d;
        int   e;
    } golden_op_t;

    typedef struct packed {
        pix_t        pix;
        logic        hit;
        logic [3:0]  index;
        logic [13:0] t;
        int          accept_cycle;
    } expect_t;

    logic         clk_in;
    logic         rst_in;
    logic         wr_en;
    logic [3:0]   wr_index;
    block_entry_t wr_entry;
    logic         pixel_valid;
    pix_t         pixel;
    logic         busy;
    logic         hit_valid;
    pix_t         pixel_out;
    logic         hit;
    logic [3:0]   block_index;
    logic [13:0]  best_t;

    golden_op_t ops [$];
    expect_t    exp_q [$];
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    int         num_pixels = 0;
    logic       loaded = 1'b0;
    int         seed;

    // shadow copy of the block table for the projection model
    logic shadow_vis [NUM_BLOCKS];
    int   shadow_bx [NUM_BLOCKS];
    int   shadow_by [NUM_BLOCKS];
    int   shadow_bz [NUM_BLOCKS];

    block_selector #(
        .NUM_BLOCKS (NUM_BLOCKS)
    ) uut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_entry    (wr_entry),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .busy        (busy),
        .hit_valid   (hit_valid),
        .pixel_out   (pixel_out),
        .hit         (hit),
        .block_index (block_index),
        .best_t      (best_t)
    );

    ////////////////////
    // clock and cycle count

    initial begin
        clk_in = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // edge number read 1 ns after the edge or at the negedge
    always @(posedge clk_in) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("CHECK FAILED at time %0t: %s got %0d expected %0d",
                     $time, name, got, expected);
        end
    endtask

    // nearest visible front-face hit from the projection rule
    function automatic void model_pixel(input int x, input int y,
                                        output int m_hit, output int m_index, output int m_t);
        int dx;
        int dy;
        int hx;
        int hy;
        int width;
        dx = x - SCREEN_W / 2;
        dy = y - SCREEN_H / 2;
        m_hit = 0;
        m_index = 0;
        m_t = int'(NO_HIT_T);
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            // floor division by the focal length
            hx = (dx * shadow_bz[i]) >>> FOCAL_SHIFT;
            hy = (dy * shadow_bz[i]) >>> FOCAL_SHIFT;
            width = (i == SABER_INDEX) ? SABER_WIDTH : BLOCK_SIZE;
            if (shadow_vis[i] && shadow_bz[i] != 0 &&
                hx >= shadow_bx[i] && hx < shadow_bx[i] + width &&
                hy >= shadow_by[i] && hy < shadow_by[i] + BLOCK_SIZE) begin
                // equal depth keeps the earlier index
                if (m_hit == 0 || shadow_bz[i] < m_t) begin
                    m_hit = 1;
                    m_index = i;
                    m_t = shadow_bz[i];
                end
            end
        end
    endfunction

    task automatic load_golden();
        int              fd;
        int              r;
        int              v [5];
        logic [7:0]      tag;
        logic [8*128-1:0] rest;
        golden_op_t      op;
        fd = $fopen("verification/golden_hits.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: golden file verification/golden_hits.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tag);
            if (r != 1) begin
                break;
            end
            if (tag == "#") begin
                // skip the rest of a column description
                r = $fgets(rest, fd);
            end else if (tag == "W" || tag == "P") begin
                r = $fscanf(fd, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
                if (r != 5) begin
                    errors++;
                    $display("ERROR: golden line of kind %s has fewer than five values", tag);
                end
                op.is_write = (tag == "W");
                op.a = v[0];
                op.b = v[1];
                op.c = v[2];
                op.d = v[3];
                op.e = v[4];
                ops.push_back(op);
            end else begin
                errors++;
                $display("ERROR: golden file has a line of unknown kind %s", tag);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk_in);
            #1;
        end
    endtask

    task automatic write_entry(input int index, input int vis, input int bx,
                               input int by, input int bz);
        // scanner has finished reading the table once busy is low
        wait_idle();
        wr_en = 1'b1;
        wr_index = 4'(index);
        wr_entry.visible = 1'(vis);
        wr_entry.bx = 12'(bx);
        wr_entry.by = 12'(by);
        wr_entry.bz = 14'(bz);
        wr_entry.spare = 1'b0;
        @(posedge clk_in);
        #1;
        wr_en = 1'b0;
        shadow_vis[index] = (vis != 0);
        shadow_bx[index] = bx;
        shadow_by[index] = by;
        shadow_bz[index] = bz;
    endtask

    task automatic send_pixel(input int x, input int y, input int exp_hit,
                              input int exp_index, input int exp_t);
        expect_t e;
        wait_idle();
        pixel_valid = 1'b1;
        pixel.x = 11'(x);
        pixel.y = 10'(y);
        @(posedge clk_in);
        #1;
        pixel_valid = 1'b0;
        check_value("busy", int'(busy), 1);
        e.pix.x = 11'(x);
        e.pix.y = 10'(y);
        e.hit = 1'(exp_hit);
        e.index = 4'(exp_index);
        e.t = 14'(exp_t);
        e.accept_cycle = cycle;
        exp_q.push_back(e);
    endtask

    // one strobe while a scan runs that must not give a result
    task automatic send_ignored_pixel(input int x, input int y);
        pixel_valid = 1'b1;
        pixel.x = 11'(x);
        pixel.y = 10'(y);
        @(posedge clk_in);
        #1;
        pixel_valid = 1'b0;
    endtask

    ////////////////////
    // result checker

    always @(negedge clk_in) begin
        expect_t e;
        if (hit_valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("ERROR at time %0t: result for pixel (%0d, %0d) with no request pending",
                         $time, pixel_out.x, pixel_out.y);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_value("pixel_out.x", int'(pixel_out.x), int'(e.pix.x));
                check_value("pixel_out.y", int'(pixel_out.y), int'(e.pix.y));
                check_value("hit", int'(hit), int'(e.hit));
                check_value("block_index", int'(block_index), int'(e.index));
                check_value("best_t", int'(best_t), int'(e.t));
                check_value("hit_valid latency", cycle - e.accept_cycle, LATENCY);
            end
        end
    end

    ////////////////////
    // watchdog

    initial begin
        wait (loaded);
        #((num_pixels * 40 + 100) * CLK_PERIOD);
        $display("ERROR: timeout, results still missing after %0d pixels worth of cycles",
                 num_pixels);
        $display("checks: %0d errors: %0d", checks, errors + 1);
        $display("test failed");
        $finish;
    end

    ////////////////////
    // stimulus

    initial begin
        int x;
        int y;
        int m_hit;
        int m_index;
        int m_t;
        seed = 32'h0432_ae7d;
        rst_in = 1'b1;
        wr_en = 1'b0;
        wr_index = 4'd0;
        wr_entry = '0;
        pixel_valid = 1'b0;
        pixel = '0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            shadow_vis[i] = 1'b0;
            shadow_bx[i] = 0;
            shadow_by[i] = 0;
            shadow_bz[i] = 0;
        end
        load_golden();
        foreach (ops[i]) begin
            if (!ops[i].is_write) begin
                num_pixels++;
            end
        end
        num_pixels += NUM_RANDOM;
        loaded = 1'b1;

        repeat (4) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        // golden section with pixels sent back to back as busy falls
        foreach (ops[i]) begin
            if (ops[i].is_write) begin
                write_entry(ops[i].a, ops[i].b, ops[i].c, ops[i].d, ops[i].e);
            end else begin
                send_pixel(ops[i].a, ops[i].b, ops[i].c, ops[i].d, ops[i].e);
            end
        end

        // random pixels around the centre with a dropped strobe after each
        for (int n = 0; n < NUM_RANDOM; n++) begin
            x = 256 + int'({$random(seed)} % 512);
            y = 192 + int'({$random(seed)} % 384);
            model_pixel(x, y, m_hit, m_index, m_t);
            send_pixel(x, y, m_hit, m_index, m_t);
            send_ignored_pixel(SCREEN_W - 1 - x, SCREEN_H - 1 - y);
        end

        while (exp_q.size() != 0) begin
            @(posedge clk_in);
        end
        // room for a stray result from a dropped strobe
        repeat (LATENCY + 2) @(posedge clk_in);
        #1;
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verification/golden_hits.txt ====
# W index visible bx by bz
# P x y expected_hit expected_index expected_t
W 0 1 -32 -32 100
P 512 384 1 0 100
P 0 0 0 0 16383
W 3 0 200 100 500
P 963 630 0 0 16383
W 3 1 200 100 500
P 963 630 1 3 500
W 5 1 -32 -32 80
P 512 384 1 5 80
W 7 1 -32 -32 80
P 512 384 1 5 80
W 14 1 -32 -32 0
P 512 384 1 5 80
P 912 384 1 5 80
P 922 384 0 0 16383
P 103 384 1 5 80
P 102 384 0 0 16383
W 9 1 300 -100 400
P 1357 180 1 9 400
W 9 0 300 -100 400
W 12 1 300 -100 400
P 1357 180 0 0 16383
P 1293 180 1 12 400

// ==== list.f ====
design/ray_pkg.sv
design/block_scanner.sv
design/pixel_to_ray.sv
design/ray_box_test.sv
design/get_intersecting_block.sv
design/nearest_hit_reduce.sv
design/block_selector.sv
verification/block_selector_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the block selector testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f \
    --top-module block_selector_tb -o block_selector_sim
./obj_dir/block_selector_sim | tee sim.log
if grep -qx "test passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
